/* hdl/csiRx_consts.svh */
`ifndef CSIRX_CONSTS_SVH
`define CSIRX_CONSTS_SVH

// geometry of the generated frame
`define CSI_LINE_BYTES 16
`define CSI_LINES 4
`define CSI_GAP_CYCLES 3

// header fields of the generated packets
`define CSI_PAT_VC 2'd0
`define CSI_FRAME_NUM 16'h0001

`endif

/* hdl/csiRx_pkg.sv */
package csiRx_pkg;

	// CSI-2 data types handled by the receiver
	typedef enum logic [5:0] {
		dtFrameStart = 6'h00,
		dtFrameEnd   = 6'h01,
		dtLineStart  = 6'h02,
		dtLineEnd    = 6'h03,
		dtRaw8       = 6'h2A
	} csiDataType_e;

	// packet header, data id in the top byte
	typedef struct packed {
		logic [1:0]   vc;
		csiDataType_e dataType;
		logic [15:0]  wordCount;
		logic [7:0]   ecc;
	} csiHeader_t;

	// one byte per lane per clock, plus start strobe and valid level
	typedef struct packed {
		logic [7:0] lane0;
		logic [7:0] lane1;
		logic       ls;
		logic       vd;
	} csiLanes_t;

	typedef struct packed {
		logic [7:0] byte0;
		logic [7:0] byte1;
		logic [1:0] byteValid;
		logic       first;
		logic       last;
	} csiPixelPair_t;

	typedef struct packed {
		logic        frameActive;
		logic        frameStart;
		logic        frameEnd;
		logic        lineDone;
		logic [15:0] lineCount;
		logic        eccErr;
		logic        lenErr;
	} csiStatus_t;

	typedef enum logic [2:0] {gsIdle, gsStart, gsHdr1, gsHdr2, gsPayload, gsGap} genState_e;
	typedef enum logic [1:0] {dsIdle, dsHdr1, dsHdr2, dsPayload} decState_e;

	// header bits covered by each ECC parity bit, P5 first
	localparam logic [5:0][23:0] eccMask = {
		24'hEFFC00, 24'hDF03F0, 24'hB8E38E, 24'h749A6D, 24'hF2555B, 24'hF12CB7
	};

	// hdrBits is {word count high, word count low, data id}
	function automatic logic [5:0] csiEcc(input logic [23:0] hdrBits);
		logic [5:0] parity;
		for (int i = 0; i < 6; i++)
			parity[i] = ^(hdrBits & eccMask[i]);
		return parity;
	endfunction

endpackage

/* hdl/hsPatternGen.sv */
`timescale 1ns/10ps
`include "csiRx_consts.svh"

module hsPatternGen (
	input  logic                 iMCLK,
	input  logic                 iRST,
	input  logic                 iPatStart,
	output csiRx_pkg::csiLanes_t lanes
);
	import csiRx_pkg::*;

	// packet 0 is frame start, 1..CSI_LINES are lines, the last is frame end
	localparam logic [7:0] lastPkt = 8'(`CSI_LINES + 1);

	genState_e   state;
	logic [7:0]  pktIdx;
	logic [15:0] byteCnt;
	logic [7:0]  gapCnt;
	csiHeader_t  curHdr;
	logic [7:0]  pixBase;
	logic        lineEnd;

	always_comb
	begin
		curHdr.vc = `CSI_PAT_VC;
		if (pktIdx == 8'd0)
		begin
			curHdr.dataType  = dtFrameStart;
			curHdr.wordCount = `CSI_FRAME_NUM;
		end
		else if (pktIdx == lastPkt)
		begin
			curHdr.dataType  = dtFrameEnd;
			curHdr.wordCount = `CSI_FRAME_NUM;
		end
		else
		begin
			curHdr.dataType  = dtRaw8;
			curHdr.wordCount = 16'(`CSI_LINE_BYTES);
		end
		curHdr.ecc = {2'b00, csiEcc({curHdr.wordCount, curHdr.vc, curHdr.dataType})};
	end

	// byte k of line n carries n + k
	assign pixBase = pktIdx - 8'd1 + byteCnt[7:0];
	assign lineEnd = (byteCnt == 16'(`CSI_LINE_BYTES));

	// state names what is on the lanes right now
	always_ff @(posedge iMCLK)
	begin
		if (iRST)
		begin
			state   <= gsIdle;
			lanes   <= '0;
			pktIdx  <= 8'd0;
			byteCnt <= 16'd0;
			gapCnt  <= 8'd0;
		end
		else
		begin
			lanes <= '0;
			case (state)
				gsIdle:
				begin
					if (iPatStart)
					begin
						state    <= gsStart;
						lanes.ls <= 1'b1;
					end
				end

				gsStart:
				begin
					state       <= gsHdr1;
					byteCnt     <= 16'd0;
					lanes.lane0 <= {curHdr.vc, curHdr.dataType};
					lanes.lane1 <= curHdr.wordCount[7:0];
					lanes.vd    <= 1'b1;
				end

				gsHdr1:
				begin
					state       <= gsHdr2;
					lanes.lane0 <= curHdr.wordCount[15:8];
					lanes.lane1 <= curHdr.ecc;
					lanes.vd    <= 1'b1;
				end

				gsHdr2, gsPayload:
				begin
					// short packets and finished lines drop into the gap
					if ((state == gsHdr2 && curHdr.dataType != dtRaw8) ||
						(state == gsPayload && lineEnd))
					begin
						state  <= gsGap;
						gapCnt <= 8'd1;
					end
					else
					begin
						state       <= gsPayload;
						byteCnt     <= byteCnt + 16'd2;
						lanes.lane0 <= pixBase;
						lanes.lane1 <= pixBase + 8'd1;
						lanes.vd    <= 1'b1;
					end
				end

				gsGap:
				begin
					if (gapCnt != 8'(`CSI_GAP_CYCLES))
						gapCnt <= gapCnt + 8'd1;
					else if (pktIdx == lastPkt)
					begin
						state  <= gsIdle;
						pktIdx <= 8'd0;
					end
					else
					begin
						state    <= gsStart;
						pktIdx   <= pktIdx + 8'd1;
						lanes.ls <= 1'b1;
					end
				end

				default:
					state <= gsIdle;
			endcase
		end
	end

endmodule

/* hdl/csiPacketDecode.sv */
`timescale 1ns/10ps

module csiPacketDecode (
	input  logic                  iMCLK,
	input  logic                  iRST,
	input  csiRx_pkg::csiLanes_t  lanes,
	output csiRx_pkg::csiHeader_t header,
	output logic                  hdrStrobe,
	output logic                  eccErr,
	output csiRx_pkg::csiLanes_t  payload,
	output logic                  burstEnd
);
	import csiRx_pkg::*;

	decState_e  state;
	logic [7:0] dataId;
	logic [7:0] wcLow;
	logic       vdQ;
	logic [7:0] eccCalc;

	// expected ecc for the header that completes on the current beat
	assign eccCalc = {2'b00, csiEcc({lanes.lane0, wcLow, dataId})};

	always_ff @(posedge iMCLK)
	begin
		if (iRST)
		begin
			state     <= dsIdle;
			hdrStrobe <= 1'b0;
			eccErr    <= 1'b0;
			payload   <= '0;
			burstEnd  <= 1'b0;
			vdQ       <= 1'b0;
		end
		else
		begin
			hdrStrobe <= 1'b0;
			eccErr    <= 1'b0;
			vdQ       <= lanes.vd;
			// falling edge of the valid level ends any burst
			burstEnd  <= vdQ & ~lanes.vd;

			// only beats after the header go out as payload
			payload.lane0 <= lanes.lane0;
			payload.lane1 <= lanes.lane1;
			payload.ls    <= 1'b0;
			payload.vd    <= (state == dsPayload) && lanes.vd;

			if (lanes.ls)
				state <= dsHdr1;
			else
			begin
				case (state)
					dsIdle:
						state <= dsIdle;

					dsHdr1:
						state <= lanes.vd ? dsHdr2 : dsIdle;

					dsHdr2:
					begin
						if (lanes.vd)
						begin
							state     <= dsPayload;
							hdrStrobe <= 1'b1;
							eccErr    <= (lanes.lane1 != eccCalc);
						end
						else
							state <= dsIdle;
					end

					dsPayload:
					begin
						if (!lanes.vd)
							state <= dsIdle;
					end

					default:
						state <= dsIdle;
				endcase
			end
		end
	end

	// header bytes, captured as they pass
	always_ff @(posedge iMCLK)
	begin
		if (lanes.vd && !lanes.ls && state == dsHdr1)
		begin
			dataId <= lanes.lane0;
			wcLow  <= lanes.lane1;
		end
		if (lanes.vd && !lanes.ls && state == dsHdr2)
		begin
			header.vc        <= dataId[7:6];
			header.dataType  <= csiDataType_e'(dataId[5:0]);
			header.wordCount <= {lanes.lane0, wcLow};
			header.ecc       <= lanes.lane1;
		end
	end

endmodule

/* hdl/csiPayloadUnpack.sv */
`timescale 1ns/10ps

module csiPayloadUnpack (
	input  logic                     iMCLK,
	input  logic                     iRST,
	input  csiRx_pkg::csiHeader_t    header,
	input  logic                     hdrStrobe,
	input  csiRx_pkg::csiLanes_t     payload,
	input  logic                     burstEnd,
	output csiRx_pkg::csiPixelPair_t pixel,
	output logic                     pairValid,
	output logic                     lenErr
);
	import csiRx_pkg::*;

	logic        active;
	logic [15:0] wordCount;
	logic [15:0] byteCnt;
	logic [15:0] remaining;
	logic        oddTail;

	// bytes still owed by the packet, wraps once it runs over
	assign remaining = wordCount - byteCnt;
	assign oddTail   = (remaining == 16'd1);

	always_ff @(posedge iMCLK)
	begin
		if (iRST)
		begin
			active    <= 1'b0;
			byteCnt   <= 16'd0;
			pairValid <= 1'b0;
			lenErr    <= 1'b0;
		end
		else
		begin
			pairValid <= 1'b0;
			lenErr    <= 1'b0;

			if (hdrStrobe)
			begin
				// short packets carry no payload to unpack
				active  <= (header.dataType == dtRaw8);
				byteCnt <= 16'd0;
			end
			else if (payload.vd && active)
			begin
				pairValid <= 1'b1;
				byteCnt   <= byteCnt + (oddTail ? 16'd1 : 16'd2);
			end

			if (burstEnd && active)
			begin
				active <= 1'b0;
				lenErr <= (byteCnt != wordCount);
			end
		end
	end

	always_ff @(posedge iMCLK)
	begin
		if (hdrStrobe)
			wordCount <= header.wordCount;
	end

	always_ff @(posedge iMCLK)
	begin
		if (payload.vd)
		begin
			pixel.byte0     <= payload.lane0;
			// lane 1 is empty on an odd final beat
			pixel.byte1     <= oddTail ? 8'h00 : payload.lane1;
			pixel.byteValid <= oddTail ? 2'b01 : 2'b11;
			pixel.first     <= (byteCnt == 16'd0);
			pixel.last      <= (remaining <= 16'd2);
		end
	end

endmodule

/* hdl/csiLineStatus.sv */
`timescale 1ns/10ps

module csiLineStatus (
	input  logic                  iMCLK,
	input  logic                  iRST,
	input  csiRx_pkg::csiHeader_t header,
	input  logic                  hdrStrobe,
	input  logic                  eccErr,
	input  logic                  burstEnd,
	input  logic                  lenErr,
	output csiRx_pkg::csiStatus_t status
);
	import csiRx_pkg::*;

	logic goodHdr;
	logic isFs;
	logic isFe;
	logic rawLine;

	// a header with a bad ecc never touches frame state
	assign goodHdr = hdrStrobe && !eccErr;
	assign isFs    = goodHdr && (header.dataType == dtFrameStart);
	assign isFe    = goodHdr && (header.dataType == dtFrameEnd);

	always_ff @(posedge iMCLK)
	begin
		if (iRST)
		begin
			status  <= '0;
			rawLine <= 1'b0;
		end
		else
		begin
			status.frameStart <= isFs;
			status.frameEnd   <= isFe;
			status.lineDone   <= burstEnd && rawLine;

			if (isFs)
				status.frameActive <= 1'b1;
			else if (isFe)
				status.frameActive <= 1'b0;

			// remember whether the open burst is a RAW8 line
			if (hdrStrobe)
				rawLine <= goodHdr && (header.dataType == dtRaw8);
			else if (burstEnd)
				rawLine <= 1'b0;

			if (isFs)
				status.lineCount <= 16'd0;
			else if (burstEnd && rawLine)
				status.lineCount <= status.lineCount + 16'd1;

			// sticky until reset
			if (hdrStrobe && eccErr)
				status.eccErr <= 1'b1;
			if (lenErr)
				status.lenErr <= 1'b1;
		end
	end

endmodule

/* hdl/csiRxTop.sv */
`timescale 1ns/10ps

module csiRxTop (
	input  logic                     iMCLK,
	input  logic                     iRST,
	input  logic                     iPatEn,
	input  logic                     iPatStart,
	input  csiRx_pkg::csiLanes_t     extLanes,
	output csiRx_pkg::csiPixelPair_t pixel,
	output logic                     pixelValid,
	output csiRx_pkg::csiStatus_t    status
);
	import csiRx_pkg::*;

	csiLanes_t  genLanes;
	csiLanes_t  rxLanes;
	csiHeader_t header;
	logic       hdrStrobe;
	logic       eccErr;
	csiLanes_t  payload;
	logic       burstEnd;
	logic       lenErr;

	hsPatternGen uPatGen (
		.iMCLK     (iMCLK),
		.iRST      (iRST),
		.iPatStart (iPatStart),
		.lanes     (genLanes)
	);

	// lane source select, one register stage
	always_ff @(posedge iMCLK)
	begin
		if (iRST)
			rxLanes <= '0;
		else
			rxLanes <= iPatEn ? genLanes : extLanes;
	end

	csiPacketDecode uDecode (
		.iMCLK     (iMCLK),
		.iRST      (iRST),
		.lanes     (rxLanes),
		.header    (header),
		.hdrStrobe (hdrStrobe),
		.eccErr    (eccErr),
		.payload   (payload),
		.burstEnd  (burstEnd)
	);

	csiPayloadUnpack uUnpack (
		.iMCLK     (iMCLK),
		.iRST      (iRST),
		.header    (header),
		.hdrStrobe (hdrStrobe),
		.payload   (payload),
		.burstEnd  (burstEnd),
		.pixel     (pixel),
		.pairValid (pixelValid),
		.lenErr    (lenErr)
	);

	csiLineStatus uStatus (
		.iMCLK     (iMCLK),
		.iRST      (iRST),
		.header    (header),
		.hdrStrobe (hdrStrobe),
		.eccErr    (eccErr),
		.burstEnd  (burstEnd),
		.lenErr    (lenErr),
		.status    (status)
	);

endmodule

/* sim/csiRx_sva.sv */
`timescale 1ns/10ps
`include "csiRx_consts.svh"

module csiRx_sva (
	input logic                     iMCLK,
	input logic                     iRST,
	input logic                     iPatEn,
	input csiRx_pkg::csiPixelPair_t pixel,
	input logic                     pixelValid,
	input csiRx_pkg::csiStatus_t    status,
	input csiRx_pkg::csiHeader_t    header,
	input logic                     hdrStrobe,
	input logic                     eccErr,
	input logic                     burstEnd,
	input logic                     lenErr
);
	import csiRx_pkg::*;

	int          errCount = 0;
	logic        inFrame;
	logic [15:0] lineDones;
	logic [15:0] pairCnt;
	logic [15:0] bytesSeen;
	logic [15:0] rawWc;
	logic        rawPkt;

	task automatic flagError(input string msg);
		errCount++;
		$error("** Error %0t: %s", $time, msg);
	endtask

	// reference model of frame progress built from the status pulses
	always_ff @(posedge iMCLK)
	begin
		if (iRST)
		begin
			inFrame   <= 1'b0;
			lineDones <= 16'd0;
			pairCnt   <= 16'd0;
			bytesSeen <= 16'd0;
			rawWc     <= 16'd0;
			rawPkt    <= 1'b0;
		end
		else
		begin
			if (status.frameStart)
				inFrame <= 1'b1;
			else if (status.frameEnd)
				inFrame <= 1'b0;
			if (status.frameStart)
				lineDones <= 16'd0;
			else if (status.lineDone)
				lineDones <= lineDones + 16'd1;
			if (status.frameStart || status.lineDone)
				pairCnt <= 16'd0;
			else if (pixelValid)
				pairCnt <= pairCnt + 16'd1;
			// payload bytes delivered for the packet now open
			if (hdrStrobe)
				bytesSeen <= 16'd0;
			else if (pixelValid)
				bytesSeen <= bytesSeen + {15'd0, pixel.byteValid[1]} + {15'd0, pixel.byteValid[0]};
			if (hdrStrobe)
			begin
				rawPkt <= (header.dataType == dtRaw8);
				rawWc  <= header.wordCount;
			end
		end
	end

	resetState: assert property (@(posedge iMCLK)
		iRST |=> !pixelValid && status == '0)
		else flagError("outputs not cleared by reset");

	oneFrameStart: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && status.frameStart |-> !inFrame)
		else flagError("second frame start inside a frame");

	lineInFrame: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && status.lineDone |-> inFrame && status.frameActive)
		else flagError("line done outside a frame");

	frameEndCount: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && status.frameEnd |->
			inFrame && lineDones == `CSI_LINES && status.lineCount == `CSI_LINES)
		else flagError("wrong line count at frame end");

	pairBytes: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && pixelValid |->
			pixel.byte0 == 8'(lineDones + (pairCnt << 1)) &&
			pixel.byte1 == 8'(lineDones + (pairCnt << 1) + 16'd1))
		else flagError("pattern byte mismatch");

	pairFlags: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && pixelValid |->
			pixel.first == (pairCnt == 16'd0) &&
			pixel.last == (pairCnt == 16'(`CSI_LINE_BYTES / 2 - 1)))
		else flagError("first or last flag misplaced");

	pairsPerLine: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && status.lineDone |-> pairCnt == 16'(`CSI_LINE_BYTES / 2))
		else flagError("wrong number of pairs in a line");

	// generator headers are always clean and the external short packet always corrupted
	genEcc: assert property (@(posedge iMCLK) disable iff (iRST)
		iPatEn && hdrStrobe |-> !eccErr)
		else flagError("ecc error on a generator header");

	extShortEcc: assert property (@(posedge iMCLK) disable iff (iRST)
		!iPatEn && hdrStrobe && header.dataType != dtRaw8 |-> eccErr)
		else flagError("flipped ecc bit not detected");

	extRawEcc: assert property (@(posedge iMCLK) disable iff (iRST)
		!iPatEn && hdrStrobe && header.dataType == dtRaw8 |-> !eccErr)
		else flagError("ecc error on a good header");

	eccSticky: assert property (@(posedge iMCLK) disable iff (iRST)
		hdrStrobe && eccErr |=>
			status.eccErr && $stable(status.frameActive) && !status.frameStart)
		else flagError("bad header not handled as error only");

	lenCheck: assert property (@(posedge iMCLK) disable iff (iRST)
		burstEnd && rawPkt |=> lenErr == (bytesSeen != rawWc))
		else flagError("length error does not match byte count");

	// a short RAW8 burst must reach the sticky flag
	lenSticky: assert property (@(posedge iMCLK) disable iff (iRST)
		(burstEnd && rawPkt) ##1 (bytesSeen != rawWc) |=> status.lenErr)
		else flagError("sticky length error not set");

	byteMask: assert property (@(posedge iMCLK) disable iff (iRST)
		pixelValid |-> pixel.byteValid == ((rawWc[0] && pixel.last) ? 2'b01 : 2'b11))
		else flagError("wrong byte-valid mask");

endmodule

/* sim/csiRx_tb.sv */
`timescale 1ns/10ps
`include "csiRx_consts.svh"

module csiRx_tb;
	import csiRx_pkg::*;

	localparam int frameLimit =
		(`CSI_LINES + 2) * (`CSI_LINE_BYTES / 2 + `CSI_GAP_CYCLES + 4) + 40;
	localparam int pktLimit = 60;

	logic          iMCLK;
	logic          iRST;
	logic          iPatEn;
	logic          iPatStart;
	csiLanes_t     extLanes;
	csiPixelPair_t pixel;
	logic          pixelValid;
	csiStatus_t    status;
	logic [15:0]   beatQ[$];
	integer        seed;
	int            cnt;

	csiRxTop UUT (
		.iMCLK      (iMCLK),
		.iRST       (iRST),
		.iPatEn     (iPatEn),
		.iPatStart  (iPatStart),
		.extLanes   (extLanes),
		.pixel      (pixel),
		.pixelValid (pixelValid),
		.status     (status)
	);

	bind csiRxTop csiRx_sva uSva (.*);

	initial
	begin
		iMCLK = 1'b0;
		forever #2 iMCLK = ~iMCLK;
	end

	// header beats: data id with wc low, then wc high with ecc
	task automatic queueHeader(input logic [5:0] dt, input logic [15:0] wc,
		input logic [7:0] eccFlip);
		logic [7:0] dataId;
		logic [7:0] ecc;
		dataId = {2'b00, dt};
		ecc    = {2'b00, csiEcc({wc, dataId})} ^ eccFlip;
		beatQ.push_back({dataId, wc[7:0]});
		beatQ.push_back({wc[15:8], ecc});
	endtask

	task automatic queuePayload(input int nBytes);
		logic [7:0] lo;
		logic [7:0] hi;
		for (int i = 0; i < nBytes; i += 2)
		begin
			lo = 8'($random(seed));
			hi = (i + 1 < nBytes) ? 8'($random(seed)) : 8'h00;
			beatQ.push_back({lo, hi});
		end
	endtask

	// Ls for one cycle, then every queued beat with Vd high
	task automatic sendBurst;
		logic [15:0] beat;
		@(posedge iMCLK);
		extLanes <= {16'h0000, 1'b1, 1'b0};
		while (beatQ.size() > 0)
		begin
			beat = beatQ.pop_front();
			@(posedge iMCLK);
			extLanes <= {beat, 1'b0, 1'b1};
		end
		@(posedge iMCLK);
		extLanes <= '0;
	endtask

	task automatic stopOnTimeout(input string what);
		$display("timeout while waiting for %s", what);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	always @(posedge iMCLK)
	begin
		if (UUT.uSva.errCount != 0)
		begin
			$display("tests failed");
			$fatal(1, "assertion failure, simulation stopped");
		end
	end

	initial
	begin
		seed      = 32'he99acad5;
		iRST      = 1'b1;
		iPatEn    = 1'b0;
		iPatStart = 1'b0;
		extLanes  = '0;
		repeat (10) @(posedge iMCLK);
		iRST <= 1'b0;

		// one generator frame
		@(posedge iMCLK);
		iPatEn    <= 1'b1;
		iPatStart <= 1'b1;
		@(posedge iMCLK);
		iPatStart <= 1'b0;
		cnt = 0;
		while (!status.frameEnd && cnt < frameLimit)
		begin
			@(posedge iMCLK);
			cnt++;
		end
		if (!status.frameEnd)
			stopOnTimeout("frame end of the generator frame");
		repeat (`CSI_GAP_CYCLES + 4) @(posedge iMCLK);
		iPatEn <= 1'b0;
		repeat (3) @(posedge iMCLK);

		// frame start with one parity bit flipped
		queueHeader(6'h00, 16'h0002, 8'h04);
		sendBurst();
		cnt = 0;
		while (!status.eccErr && cnt < pktLimit)
		begin
			@(posedge iMCLK);
			cnt++;
		end
		if (!status.eccErr)
			stopOnTimeout("sticky ecc error");

		// RAW8 with an odd word count
		queueHeader(6'h2A, 16'd5, 8'h00);
		queuePayload(5);
		sendBurst();
		cnt = 0;
		while (!(pixelValid && pixel.last) && cnt < pktLimit)
		begin
			@(posedge iMCLK);
			cnt++;
		end
		if (!(pixelValid && pixel.last))
			stopOnTimeout("last pair of the odd packet");
		repeat (4) @(posedge iMCLK);

		// RAW8 cut short of its word count
		queueHeader(6'h2A, 16'd10, 8'h00);
		queuePayload(6);
		sendBurst();
		cnt = 0;
		while (!status.lenErr && cnt < pktLimit)
		begin
			@(posedge iMCLK);
			cnt++;
		end
		if (!status.lenErr)
			stopOnTimeout("sticky length error");
		repeat (4) @(posedge iMCLK);

		if (UUT.uSva.errCount == 0)
		begin
			$display("all tests passed");
			$finish;
		end
		else
		begin
			$display("tests failed");
			$fatal(1, "assertion failure, simulation stopped");
		end
	end

endmodule

/* sources.f */
+incdir+hdl
hdl/csiRx_pkg.sv
hdl/hsPatternGen.sv
hdl/csiPacketDecode.sv
hdl/csiPayloadUnpack.sv
hdl/csiLineStatus.sv
hdl/csiRxTop.sv
sim/csiRx_sva.sv
sim/csiRx_tb.sv
